// ==== hdl/sdram_pkg.sv ====
// Shared SDRAM controller types and constants, referenced by scoped name from the RTL and testbench
package sdram_pkg;

    // Pin command, bit order {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_MODE      = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111
    } sdram_cmd_e;

    // Word address field widths
    localparam int BANK_W      = 2;
    localparam int ROW_W       = 13;
    localparam int COL_W       = 9;
    localparam int WORD_ADDR_W = BANK_W + ROW_W + COL_W;

    // Word address split, bank in the top bits
    typedef struct packed {
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
    } mem_addr_t;

    // One memory access from the bus side
    typedef struct packed {
        logic        valid;
        logic        write;
        mem_addr_t   addr;
        logic [15:0] wdata;
        logic [1:0]  be;      // Byte enables, bit 1 is the high byte
    } mem_req_t;

    // Column view of the SDRAM address bus
    typedef struct packed {
        logic [1:0] spare;
        logic       all_banks;   // A10, precharge all or auto precharge
        logic [9:0] col;
    } sdram_col_t;

    // Address bus as a row for ACTIVE, as a column for READ, WRITE, PRECHARGE and MODE
    typedef union packed {
        logic [ROW_W-1:0] row;
        sdram_col_t       colv;
    } sdram_addr_u;

    // Everything the phy puts on the pins for one cycle
    typedef struct packed {
        sdram_cmd_e        cmd;
        logic [BANK_W-1:0] ba;
        sdram_addr_u       addr;
        logic [1:0]        dqm;
        logic [15:0]       wdata;
        logic              wvalid;
    } sdram_pin_cmd_t;

    // Mode bits other than CAS latency (6:4), burst length 1 and sequential
    localparam logic [9:0] MODE_BURST1 = 10'b0_00_000_0_000;

endpackage

// ==== hdl/apb_mem_port.sv ====
// APB slave front end that turns each APB transfer into one held memory request
`timescale 1ns/10ps

module apb_mem_port (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [sdram_pkg::WORD_ADDR_W:0]   paddr,
    input  logic [15:0]                       pwdata,
    input  logic [1:0]                        pstrb,
    output logic [15:0]                       prdata,
    output logic                              pready,
    output sdram_pkg::mem_req_t               req,
    input  logic                              done,
    input  logic [15:0]                       rd_data
);

    logic start;

    // Access phase with nothing in flight
    // The pready cycle is excluded so a finishing transfer is not taken twice
    assign start = psel && penable && !req.valid && !pready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req.valid <= 1'b0;
            pready    <= 1'b0;
        end else begin
            // Single pready pulse, one cycle after done
            pready <= done;
            if (done) begin
                req.valid <= 1'b0;
                // Read word for the completing transfer
                if (!req.write) begin
                    prdata <= rd_data;
                end
            end else if (start) begin
                req.valid <= 1'b1;
                req.write <= pwrite;
                // Byte address to word address, bit 0 dropped
                // Strobes take its place
                req.addr  <= sdram_pkg::mem_addr_t'(paddr[sdram_pkg::WORD_ADDR_W:1]);
                req.wdata <= pwdata;
                // Reads always fetch both bytes
                req.be    <= pwrite ? pstrb : 2'b11;
            end
        end
    end

endmodule

// ==== hdl/sdram_sequencer.sv ====
// Command sequencer for init, refresh and single word accesses, stepping once per sync slot
`timescale 1ns/10ps

module sdram_sequencer #(
    parameter int SYNC_DIV    = 2,
    parameter int INIT_WAIT   = 20,
    parameter int CAS_LATENCY = 2
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  sdram_pkg::mem_req_t       req,
    output logic                      done,
    output logic [15:0]               rd_data,
    input  logic                      ref_req,
    output logic                      ref_grant,
    output sdram_pkg::sdram_pin_cmd_t pin_cmd,
    input  logic                      rd_valid,
    input  logic [15:0]               rd_word
);

    localparam int PH_W = (SYNC_DIV > 1) ? $clog2(SYNC_DIV) : 1;
    localparam int IW_W = $clog2(INIT_WAIT + 1);

    // Column view for precharge of all banks
    localparam sdram_pkg::sdram_col_t PRE_ALL = '{spare: 2'b00, all_banks: 1'b1, col: 10'd0};
    // Mode register word with CAS latency in 6:4
    localparam logic [9:0] MODE_WORD = sdram_pkg::MODE_BURST1 | 10'(CAS_LATENCY << 4);

    typedef enum logic [3:0] {
        S_INIT, S_INIT_REF1, S_INIT_REF2, S_INIT_MODE,
        S_IDLE, S_ACT, S_RD_WAIT, S_WR, S_PRE, S_REF
    } state_e;

    state_e          state;
    logic [PH_W-1:0] phase;
    logic            sync;
    logic [IW_W-1:0] init_cnt;
    logic [1:0]      slot_cnt;
    logic            rd_seen;

    // Sync slot every SYNC_DIV cycles
    assign sync = (phase == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (phase == PH_W'(SYNC_DIV - 1)) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= S_INIT;
            init_cnt       <= IW_W'(INIT_WAIT);
            slot_cnt       <= '0;
            rd_seen        <= 1'b0;
            done           <= 1'b0;
            ref_grant      <= 1'b0;
            pin_cmd.cmd    <= sdram_pkg::CMD_NOP;
            pin_cmd.dqm    <= 2'b11;
            pin_cmd.wvalid <= 1'b0;
        end else begin
            // Commands and pulses last one cycle
            pin_cmd.cmd    <= sdram_pkg::CMD_NOP;
            pin_cmd.dqm    <= 2'b11;
            pin_cmd.wvalid <= 1'b0;
            done           <= 1'b0;
            ref_grant      <= 1'b0;

            // Power-up wait, counted in cycles
            if (init_cnt != '0) begin
                init_cnt <= init_cnt - 1'b1;
            end

            // Read word can land between slots; note it and finish on the next slot
            if (state == S_RD_WAIT && rd_valid) begin
                done    <= 1'b1;
                rd_data <= rd_word;
                rd_seen <= 1'b1;
            end

            if (sync) begin
                case (state)
                    S_INIT: begin
                        if (init_cnt == '0) begin
                            pin_cmd.cmd       <= sdram_pkg::CMD_PRECHARGE;
                            pin_cmd.addr.colv <= PRE_ALL;
                            state             <= S_INIT_REF1;
                        end
                    end
                    S_INIT_REF1: begin
                        pin_cmd.cmd <= sdram_pkg::CMD_REFRESH;
                        state       <= S_INIT_REF2;
                    end
                    S_INIT_REF2: begin
                        pin_cmd.cmd <= sdram_pkg::CMD_REFRESH;
                        state       <= S_INIT_MODE;
                    end
                    S_INIT_MODE: begin
                        pin_cmd.cmd       <= sdram_pkg::CMD_MODE;
                        pin_cmd.ba        <= '0;
                        pin_cmd.addr.colv <= '{spare: 2'b00, all_banks: 1'b0, col: MODE_WORD};
                        state             <= S_IDLE;
                    end
                    S_IDLE: begin
                        // Access beats refresh; a refresh waits at most one access
                        if (req.valid) begin
                            pin_cmd.cmd      <= sdram_pkg::CMD_ACTIVE;
                            pin_cmd.ba       <= req.addr.bank;
                            pin_cmd.addr.row <= req.addr.row;
                            state            <= S_ACT;
                        end else if (ref_req) begin
                            pin_cmd.cmd <= sdram_pkg::CMD_REFRESH;
                            ref_grant   <= 1'b1;
                            slot_cnt    <= '0;
                            state       <= S_REF;
                        end
                    end
                    S_ACT: begin
                        // Request is held by the bus side, so its address is still valid
                        pin_cmd.ba        <= req.addr.bank;
                        pin_cmd.addr.colv <= '{spare: 2'b00, all_banks: 1'b0,
                                               col: {1'b0, req.addr.col}};
                        if (req.write) begin
                            pin_cmd.cmd    <= sdram_pkg::CMD_WRITE;
                            pin_cmd.dqm    <= ~req.be;
                            pin_cmd.wdata  <= req.wdata;
                            pin_cmd.wvalid <= 1'b1;
                            done           <= 1'b1;
                            state          <= S_WR;
                        end else begin
                            pin_cmd.cmd <= sdram_pkg::CMD_READ;
                            pin_cmd.dqm <= 2'b00;
                            state       <= S_RD_WAIT;
                        end
                    end
                    S_RD_WAIT: begin
                        if (rd_seen) begin
                            pin_cmd.cmd       <= sdram_pkg::CMD_PRECHARGE;
                            pin_cmd.addr.colv <= PRE_ALL;
                            rd_seen           <= 1'b0;
                            state             <= S_IDLE;
                        end
                    end
                    // One spare slot for write recovery
                    S_WR: state <= S_PRE;
                    S_PRE: begin
                        pin_cmd.cmd       <= sdram_pkg::CMD_PRECHARGE;
                        pin_cmd.addr.colv <= PRE_ALL;
                        state             <= S_IDLE;
                    end
                    S_REF: begin
                        // Refresh cycle time
                        if (slot_cnt == 2'd3) begin
                            state <= S_IDLE;
                        end else begin
                            slot_cnt <= slot_cnt + 1'b1;
                        end
                    end
                    default: state <= S_INIT;
                endcase
            end
        end
    end

endmodule

// ==== hdl/refresh_timer.sv ====
// Free-running refresh interval timer that raises and holds a refresh request until granted
`timescale 1ns/10ps

module refresh_timer #(
    parameter int REFRESH_INTERVAL = 200
) (
    input  logic clk,
    input  logic rst_n,
    input  logic ref_grant,
    output logic ref_req
);

    localparam int CNT_W = $clog2(REFRESH_INTERVAL + 1);

    logic [CNT_W-1:0] count;
    logic             expire;

    // Last cycle of the interval
    assign expire = (count == CNT_W'(1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count   <= CNT_W'(REFRESH_INTERVAL);
            ref_req <= 1'b0;
        end else begin
            // Reload on expiry, not on grant, so the period stays fixed
            if (expire) begin
                count <= CNT_W'(REFRESH_INTERVAL);
            end else begin
                count <= count - 1'b1;
            end
            // New expiry wins over a grant in the same cycle
            if (expire) begin
                ref_req <= 1'b1;
            end else if (ref_grant) begin
                ref_req <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/sdram_phy.sv ====
// SDRAM pin stage that registers command and write data and captures read data at CAS latency
`timescale 1ns/10ps

module sdram_phy #(
    parameter int CAS_LATENCY = 2
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  sdram_pkg::sdram_pin_cmd_t      pin_cmd,
    output sdram_pkg::sdram_cmd_e          sd_cmd,
    output logic [sdram_pkg::BANK_W-1:0]   sd_ba,
    output logic [sdram_pkg::ROW_W-1:0]    sd_addr,
    output logic [1:0]                     sd_dqm,
    output logic [15:0]                    dq_out,
    output logic                           dq_oe,
    input  logic [15:0]                    dq_in,
    output logic                           rd_valid,
    output logic [15:0]                    rd_word
);

    // One bit per cycle since each READ reached the pins
    logic [CAS_LATENCY-1:0] rd_pipe;

    // Control pins and read tracking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sd_cmd   <= sdram_pkg::CMD_NOP;
            sd_dqm   <= 2'b11;
            dq_oe    <= 1'b0;
            rd_pipe  <= '0;
            rd_valid <= 1'b0;
        end else begin
            sd_cmd   <= pin_cmd.cmd;
            sd_dqm   <= pin_cmd.dqm;
            dq_oe    <= pin_cmd.wvalid;
            // Several reads may be in flight
            rd_pipe  <= (rd_pipe << 1) | CAS_LATENCY'(pin_cmd.cmd == sdram_pkg::CMD_READ);
            rd_valid <= rd_pipe[CAS_LATENCY-1];
        end
    end

    // Address and data pins
    always_ff @(posedge clk) begin
        sd_ba   <= pin_cmd.ba;
        // Union bits go out as is, whichever view the sequencer filled
        sd_addr <= pin_cmd.addr;
        dq_out  <= pin_cmd.wdata;
        // dq_in sampled CAS_LATENCY edges after the edge that drove READ out
        if (rd_pipe[CAS_LATENCY-1]) begin
            rd_word <= dq_in;
        end
    end

endmodule

// ==== hdl/sdram_ctrl_top.sv ====
// APB to SDR SDRAM controller top level, connects the bus port, sequencer, refresh timer and phy
`timescale 1ns/10ps

module sdram_ctrl_top #(
    parameter int SYNC_DIV         = 2,
    parameter int CAS_LATENCY      = 2,
    parameter int REFRESH_INTERVAL = 200,
    parameter int INIT_WAIT        = 20
) (
    input  logic                            clk,
    input  logic                            rst_n,
    // APB slave
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [sdram_pkg::WORD_ADDR_W:0] paddr,
    input  logic [15:0]                     pwdata,
    input  logic [1:0]                      pstrb,
    output logic [15:0]                     prdata,
    output logic                            pready,
    // SDRAM pins, data bus split by direction
    output sdram_pkg::sdram_cmd_e           sd_cmd,
    output logic [sdram_pkg::BANK_W-1:0]    sd_ba,
    output logic [sdram_pkg::ROW_W-1:0]     sd_addr,
    output logic [1:0]                      sd_dqm,
    output logic [15:0]                     dq_out,
    output logic                            dq_oe,
    input  logic [15:0]                     dq_in
);

    sdram_pkg::mem_req_t       req;
    logic                      done;
    logic [15:0]               rd_data;
    logic                      ref_req;
    logic                      ref_grant;
    sdram_pkg::sdram_pin_cmd_t pin_cmd;
    logic                      rd_valid;
    logic [15:0]               rd_word;

    apb_mem_port u_apb (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .req     (req),
        .done    (done),
        .rd_data (rd_data)
    );

    sdram_sequencer #(
        .SYNC_DIV    (SYNC_DIV),
        .INIT_WAIT   (INIT_WAIT),
        .CAS_LATENCY (CAS_LATENCY)
    ) u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .done      (done),
        .rd_data   (rd_data),
        .ref_req   (ref_req),
        .ref_grant (ref_grant),
        .pin_cmd   (pin_cmd),
        .rd_valid  (rd_valid),
        .rd_word   (rd_word)
    );

    refresh_timer #(
        .REFRESH_INTERVAL (REFRESH_INTERVAL)
    ) u_ref (
        .clk       (clk),
        .rst_n     (rst_n),
        .ref_grant (ref_grant),
        .ref_req   (ref_req)
    );

    sdram_phy #(
        .CAS_LATENCY (CAS_LATENCY)
    ) u_phy (
        .clk      (clk),
        .rst_n    (rst_n),
        .pin_cmd  (pin_cmd),
        .sd_cmd   (sd_cmd),
        .sd_ba    (sd_ba),
        .sd_addr  (sd_addr),
        .sd_dqm   (sd_dqm),
        .dq_out   (dq_out),
        .dq_oe    (dq_oe),
        .dq_in    (dq_in),
        .rd_valid (rd_valid),
        .rd_word  (rd_word)
    );

endmodule

// ==== dv/sdram_model.sv ====
// Behavioural SDR SDRAM for simulation, decodes the pin commands and returns read data after CAS latency
`timescale 1ns/10ps

module sdram_model #(
    parameter int CAS_LATENCY = 2
) (
    input  logic                         clk,
    input  sdram_pkg::sdram_cmd_e        sd_cmd,
    input  logic [sdram_pkg::BANK_W-1:0] sd_ba,
    input  logic [sdram_pkg::ROW_W-1:0]  sd_addr,
    input  logic [1:0]                   sd_dqm,
    input  logic [15:0]                  dq_out,
    input  logic                         dq_oe,
    output logic [15:0]                  dq_in
);

    // Storage keyed by {bank, row, column}, unwritten words read as zero
    logic [15:0]                 mem [logic [sdram_pkg::WORD_ADDR_W-1:0]];
    logic [sdram_pkg::ROW_W-1:0] open_row [1 << sdram_pkg::BANK_W];
    // CAS latency field from the last MODE command
    logic [2:0]                  mode_cl;
    // Read data on its way to the bus, one stage fewer than CAS latency
    logic [15:0]                 rd_pipe [CAS_LATENCY-1];

    assign dq_in = rd_pipe[CAS_LATENCY-2];

    initial begin
        for (int i = 0; i < CAS_LATENCY - 1; i++) begin
            rd_pipe[i] = 16'h0000;
        end
        mode_cl = 3'd0;
    end

    always @(posedge clk) begin
        sdram_pkg::sdram_addr_u a;
        sdram_pkg::mem_addr_t   key;
        logic [15:0]            word;
        a        = sd_addr;
        // Column commands use the row opened in the same bank
        key.bank = sd_ba;
        key.row  = open_row[sd_ba];
        key.col  = a.colv.col[sdram_pkg::COL_W-1:0];
        word     = mem.exists(key) ? mem[key] : 16'h0000;
        for (int i = CAS_LATENCY - 2; i > 0; i--) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
        rd_pipe[0] <= 16'h0000;
        case (sd_cmd)
            sdram_pkg::CMD_ACTIVE: open_row[sd_ba] <= a.row;
            sdram_pkg::CMD_READ:   rd_pipe[0] <= word;
            sdram_pkg::CMD_WRITE: begin
                // A set dqm bit masks its byte lane
                if (dq_oe) begin
                    if (!sd_dqm[1]) word[15:8] = dq_out[15:8];
                    if (!sd_dqm[0]) word[7:0] = dq_out[7:0];
                    mem[key] = word;
                end
            end
            sdram_pkg::CMD_MODE:   mode_cl <= a.colv.col[6:4];
            default: ;
        endcase
    end

endmodule

// ==== dv/sdram_ctrl_sva.sv ====
// Concurrent checks on the SDRAM pin protocol and the APB handshake, bound to the controller top
`timescale 1ns/10ps

module sdram_ctrl_sva (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  psel,
    input logic                  penable,
    input logic                  pready,
    input sdram_pkg::sdram_cmd_e sd_cmd,
    input logic                  dq_oe
);

    // Set by ACTIVE, cleared by PRECHARGE all
    logic row_open;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_open <= 1'b0;
        end else if (sd_cmd == sdram_pkg::CMD_ACTIVE) begin
            row_open <= 1'b1;
        end else if (sd_cmd == sdram_pkg::CMD_PRECHARGE) begin
            row_open <= 1'b0;
        end
    end

    // Data bus only driven together with WRITE
    a_oe_on_write: assert property (@(posedge clk) disable iff (!rst_n)
        dq_oe |-> sd_cmd == sdram_pkg::CMD_WRITE)
        else $error("dq_oe high without a WRITE command");

    // Row must be closed before the next ACTIVE
    a_act_after_pre: assert property (@(posedge clk) disable iff (!rst_n)
        sd_cmd == sdram_pkg::CMD_ACTIVE |-> !row_open)
        else $error("ACTIVE issued with a row still open");

    a_pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> psel && penable)
        else $error("pready high outside an APB access phase");

    // Reset forces NOP onto the pins by the next edge
    a_nop_in_reset: assert property (@(posedge clk)
        !rst_n |=> sd_cmd == sdram_pkg::CMD_NOP)
        else $error("command pins not NOP during reset");

endmodule

// ==== dv/tb_sdram_ctrl.sv ====
// Testbench for the APB SDRAM controller, random transfers checked against a reference memory
`timescale 1ns/10ps

module tb_sdram_ctrl;

    localparam int SYNC_DIV         = 2;
    localparam int CAS_LATENCY      = 2;
    localparam int REFRESH_INTERVAL = 200;
    localparam int INIT_WAIT        = 20;
    localparam int AW               = sdram_pkg::WORD_ADDR_W;
    localparam int NUM_XFERS        = 300;
    // Idle gap, APB phases, a refresh in the way and the longest access
    localparam int XFER_CYCLES      = 48;
    localparam int INIT_CYCLES      = 4 + INIT_WAIT + 8 * SYNC_DIV;
    localparam int TIMEOUT          = NUM_XFERS * XFER_CYCLES + INIT_CYCLES + 500;
    // How long one access can hold off a pending refresh
    localparam int WORST_ACCESS     = 16;
    localparam int REF_BOUND        = REFRESH_INTERVAL + WORST_ACCESS;

    logic                         clk;
    logic                         rst_n;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [AW:0]                  paddr;
    logic [15:0]                  pwdata;
    logic [1:0]                   pstrb;
    logic [15:0]                  prdata;
    logic                         pready;
    sdram_pkg::sdram_cmd_e        sd_cmd;
    logic [sdram_pkg::BANK_W-1:0] sd_ba;
    logic [sdram_pkg::ROW_W-1:0]  sd_addr;
    logic [1:0]                   sd_dqm;
    logic [15:0]                  dq_out;
    logic                         dq_oe;
    logic [15:0]                  dq_in;

    logic [31:0]          lfsr;
    logic [15:0]          ref_mem [logic [AW-1:0]];
    logic [AW-1:0]        pool [8];
    // Word address of the transfer in flight, split by the package struct
    sdram_pkg::mem_addr_t cur_addr;
    logic                 mode_seen = 1'b0;
    int                   cycle = 0;
    int                   init_cmds = 0;
    int                   periodic_refs = 0;
    int                   last_ref_cycle = 0;
    int                   mode_cycle = 0;

    sdram_ctrl_top #(
        .SYNC_DIV         (SYNC_DIV),
        .CAS_LATENCY      (CAS_LATENCY),
        .REFRESH_INTERVAL (REFRESH_INTERVAL),
        .INIT_WAIT        (INIT_WAIT)
    ) dut (.*);

    sdram_model #(.CAS_LATENCY(CAS_LATENCY)) u_model (.*);

    bind sdram_ctrl_top sdram_ctrl_sva u_sva (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable),
        .pready(pready), .sd_cmd(sd_cmd), .dq_oe(dq_oe)
    );

    always #2 clk = ~clk;

    // Galois LFSR, x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic fail_run(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation stopped on error");
        end
    endtask

    // Setup phase, access phase, then hold until pready
    task automatic apb_xfer(input logic wr, input logic [AW-1:0] waddr, input logic [15:0] wdata,
                            input logic [1:0] strb, output logic [15:0] rdata);
        cur_addr = sdram_pkg::mem_addr_t'(waddr);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= {waddr, 1'b0};
        pwdata  <= wdata;
        pstrb   <= strb;
        @(posedge clk);
        penable <= 1'b1;
        do @(posedge clk); while (pready !== 1'b1);
        if (!mode_seen) fail_run("APB transfer completed before the MODE command");
        rdata = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) fail_run($sformatf("run timed out after %0d cycles", cycle));
    end

    // Pin monitor for init order, address split and refresh spacing
    always @(posedge clk) begin
        sdram_pkg::sdram_addr_u a;
        a = sd_addr;
        if (rst_n && sd_cmd != sdram_pkg::CMD_NOP) begin
            if (init_cmds < 4) begin
                case (init_cmds)
                    0: begin
                        check_eq(sd_cmd, sdram_pkg::CMD_PRECHARGE, "first init command");
                        check_eq(a.colv.all_banks, 1'b1, "init precharge all-bank flag");
                    end
                    1, 2: check_eq(sd_cmd, sdram_pkg::CMD_REFRESH, "init refresh command");
                    default: begin
                        check_eq(sd_cmd, sdram_pkg::CMD_MODE, "last init command");
                        check_eq(a.colv.col[6:4], CAS_LATENCY, "MODE CAS latency field");
                        mode_seen  = 1'b1;
                        mode_cycle = cycle;
                    end
                endcase
                init_cmds++;
            end
            if (sd_cmd == sdram_pkg::CMD_ACTIVE) begin
                check_eq(sd_ba, cur_addr.bank, "ACTIVE bank");
                check_eq(a.row, cur_addr.row, "ACTIVE row");
            end
            if (sd_cmd == sdram_pkg::CMD_READ || sd_cmd == sdram_pkg::CMD_WRITE) begin
                check_eq(sd_ba, cur_addr.bank, "column command bank");
                check_eq(a.colv.col, {1'b0, cur_addr.col}, "column command column");
            end
            // Reads fetch both bytes
            if (sd_cmd == sdram_pkg::CMD_READ) begin
                check_eq(sd_dqm, 2'b00, "READ byte mask");
            end
            if (sd_cmd == sdram_pkg::CMD_REFRESH) begin
                if (cycle - last_ref_cycle > REF_BOUND) begin
                    fail_run($sformatf("refresh gap of %0d cycles exceeds %0d",
                                       cycle - last_ref_cycle, REF_BOUND));
                end
                last_ref_cycle = cycle;
                if (mode_seen) periodic_refs++;
            end
        end
    end

    initial begin
        int            op;
        int            gap;
        logic [AW-1:0] waddr;
        logic [15:0]   wdata;
        logic [15:0]   rdata;
        logic [15:0]   old;
        logic [1:0]    strb;
        clk     = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pstrb   = '0;
        lfsr    = 32'h3202;
        // Small pool with neighbours that differ only in bank, row or column
        pool[0] = rand_bits(AW);
        pool[1] = pool[0] ^ (AW'(1) << (sdram_pkg::ROW_W + sdram_pkg::COL_W));
        pool[2] = pool[0] ^ (AW'(1) << sdram_pkg::COL_W);
        pool[3] = pool[0] ^ AW'(1);
        for (int i = 4; i < 8; i++) pool[i] = rand_bits(AW);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int n = 0; n < NUM_XFERS; n++) begin
            op    = rand_bits(2);
            waddr = pool[rand_bits(3)];
            wdata = rand_bits(16);
            strb  = rand_bits(2);
            // Idle cycles between transfers let a waiting refresh in
            gap   = 2 + rand_bits(2);
            if (strb == 2'b00) strb = 2'b11;
            // Random address outside the pool, almost always unwritten
            if (op == 3) waddr = rand_bits(AW);
            repeat (gap) @(posedge clk);
            if (op == 1 || op == 2) begin
                apb_xfer(1'b1, waddr, wdata, strb, rdata);
                old = ref_mem.exists(waddr) ? ref_mem[waddr] : 16'h0000;
                ref_mem[waddr] = {strb[1] ? wdata[15:8] : old[15:8],
                                  strb[0] ? wdata[7:0] : old[7:0]};
            end else begin
                apb_xfer(1'b0, waddr, 16'h0000, 2'b00, rdata);
                check_eq(rdata, ref_mem.exists(waddr) ? ref_mem[waddr] : 16'h0000,
                         $sformatf("read data at word %0h", waddr));
            end
        end
        if (periodic_refs < (cycle - mode_cycle) / REF_BOUND) begin
            fail_run($sformatf("only %0d refreshes in %0d cycles", periodic_refs,
                               cycle - mode_cycle));
        end
        if (cycle - last_ref_cycle > REF_BOUND) begin
            fail_run("refresh stopped before the end of the run");
        end
        check_eq(u_model.mode_cl, CAS_LATENCY, "CAS latency in the model mode register");
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== list.f ====
hdl/sdram_pkg.sv
hdl/apb_mem_port.sv
hdl/sdram_sequencer.sv
hdl/refresh_timer.sv
hdl/sdram_phy.sv
hdl/sdram_ctrl_top.sv
dv/sdram_model.sv
dv/sdram_ctrl_sva.sv
dv/tb_sdram_ctrl.sv
